// ==== fxp_coproc.f ====
rtl/fxp_pkg.sv
rtl/result_if.sv
rtl/fxp_decoder.sv
rtl/sqrt_unit.sv
rtl/div_unit.sv
rtl/writeback_arbiter.sv
rtl/fxp_coproc.sv
test/fxp_coproc_tb.sv

// ==== Bender.yml ====
package:
  name: fxp_coproc

sources:
  - rtl/fxp_pkg.sv
  - rtl/result_if.sv
  - rtl/fxp_decoder.sv
  - rtl/sqrt_unit.sv
  - rtl/div_unit.sv
  - rtl/writeback_arbiter.sv
  - rtl/fxp_coproc.sv
  - target: test
    files:
      - test/fxp_coproc_tb.sv

// ==== test/fxp_coproc_tb.sv ====
`timescale 1ns/1ps

module fxp_coproc_tb
    import fxp_pkg::*;
();

    localparam int          TIMEOUT = 3 * DIV_ITER;
    localparam logic [31:0] SEED    = 32'h457a;

    logic                CLK;
    logic                reset;
    logic                issue;
    logic [6:0]          opcode;
    logic [6:0]          funct7;
    logic [REG_BITS-1:0] rd;
    logic [WIDTH-1:0]    rs1;
    logic [WIDTH-1:0]    rs2;
    logic                sqrt_busy;
    logic                div_busy;
    logic                wb_valid;
    logic [REG_BITS-1:0] wb_rd;
    logic [WIDTH-1:0]    wb_data;

    int edges    = 0;
    int errors   = 0;
    int checks   = 0;
    int timeouts = 0;
    int tag      = 0;
    int slack    = 0; // cycles a result may wait behind the other unit.

    // one entry per accepted instruction.
    logic [REG_BITS-1:0] exp_rd[$];
    logic [WIDTH-1:0]    exp_data[$];
    int                  exp_edge[$];
    int                  exp_slack[$];
    bit                  exp_div[$];
    bit                  wb_order[$]; // 1 for a divide writeback.

    fxp_coproc DUT (.*);

    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #50;
            edges = edges + 1; // counted first so waiters on the edge see it.
            CLK   = 1'b1;
            #50 CLK = 1'b0;
        end
    end

    function automatic logic [WIDTH-1:0] root_of(input logic [WIDTH-1:0] a);
        longint unsigned v;
        longint unsigned lo;
        longint unsigned hi;
        longint unsigned mid;
        v  = {32'd0, a} << FBITS;
        lo = 0;
        hi = 64'd1 << SQRT_ITER;
        while (hi - lo > 1)
        begin
            mid = (lo + hi) / 2;
            if (mid * mid <= v)
                lo = mid;
            else
                hi = mid;
        end
        return lo[WIDTH-1:0];
    endfunction

    function automatic logic [WIDTH-1:0] quotient_of(input logic [WIDTH-1:0] a,
                                                     input logic [WIDTH-1:0] b);
        longint unsigned q;
        if (b == 0)
            return '1;
        q = ({32'd0, a} << FBITS) / {32'd0, b};
        return q[WIDTH-1:0];
    endfunction

    function automatic logic [WIDTH-1:0] rand_operand();
        case ($urandom_range(0, 5))
            0: return '0;
            1: return '1;
            2: return 32'd1;
            default: return $urandom;
        endcase
    endfunction

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    endtask

    task automatic give_up(input string why);
        timeouts = timeouts + 1;
        $display("timeout at %0t: %s", $time, why);
        finish_run();
    endtask

    task automatic expect_true(input bit ok, input string what);
        checks = checks + 1;
        assert (ok)
        else
        begin
            errors = errors + 1;
            $display("** Error at %0t: %s", $time, what);
        end
    endtask

    task automatic await_idle(input bit on_div);
        int n;
        n = 0;
        while ((on_div ? div_busy : sqrt_busy) && n < TIMEOUT)
        begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (on_div ? div_busy : sqrt_busy)
            give_up("a unit stayed busy far longer than its latency");
    endtask

    task automatic drain_results();
        int n;
        n = 0;
        while (exp_rd.size() > 0 && n < TIMEOUT)
        begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (exp_rd.size() > 0)
            give_up("an accepted instruction never wrote back");
    endtask

    // the issue is sampled on edge at_edge.
    task automatic send_at(input int at_edge, input logic [6:0] opc, input logic [6:0] f7,
                           input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                           input bit accept);
        bit                  to_div;
        bit                  sq_before;
        bit                  dv_before;
        logic [REG_BITS-1:0] r;
        to_div = (f7 == FUNCT7_FDIV);
        r      = REG_BITS'(tag);
        tag++;
        while (edges < at_edge - 1)
        begin
            @(posedge CLK);
            #1;
        end
        sq_before = sqrt_busy;
        dv_before = div_busy;
        issue  = 1'b1;
        opcode = opc;
        funct7 = f7;
        rd     = r;
        rs1    = a;
        rs2    = b;
        @(posedge CLK);
        #1;
        issue = 1'b0;
        if (accept)
        begin
            exp_rd.push_back(r);
            exp_data.push_back(to_div ? quotient_of(a, b) : root_of(a));
            exp_edge.push_back(edges + (to_div ? DIV_ITER : SQRT_ITER) + 1);
            exp_slack.push_back(slack);
            exp_div.push_back(to_div);
            expect_true(to_div ? div_busy : sqrt_busy, "busy did not rise after an issue");
        end
        expect_true(sq_before || !sqrt_busy || (accept && !to_div), "sqrt_busy rose unasked");
        expect_true(dv_before || !div_busy || (accept && to_div), "div_busy rose unasked");
    endtask

    // match each writeback against the expected results by rd.
    always @(negedge CLK)
    begin
        int idx;
        if (!reset && wb_valid)
        begin
            idx = -1;
            foreach (exp_rd[i])
            begin
                if (idx < 0 && exp_rd[i] == wb_rd)
                    idx = i;
            end
            expect_true(idx >= 0, $sformatf("writeback to rd %0d was not expected", wb_rd));
            if (idx >= 0)
            begin
                expect_true(wb_data == exp_data[idx], $sformatf("rd %0d data %h, expected %h",
                            wb_rd, wb_data, exp_data[idx]));
                expect_true(edges >= exp_edge[idx] && edges <= exp_edge[idx] + exp_slack[idx],
                            $sformatf("rd %0d written at edge %0d, expected edge %0d",
                            wb_rd, edges, exp_edge[idx]));
                wb_order.push_back(exp_div[idx]);
                exp_rd.delete(idx);
                exp_data.delete(idx);
                exp_edge.delete(idx);
                exp_slack.delete(idx);
                exp_div.delete(idx);
            end
        end
    end

    assert property (@(posedge CLK) reset |=> (!sqrt_busy && !div_busy && !wb_valid))
    else
    begin
        errors = errors + 1;
        $display("** Error at %0t: busy or wb_valid high after reset", $time);
    end

    assert property (@(posedge CLK) disable iff (reset) (wb_valid && $past(wb_valid))
                     |-> (wb_rd != $past(wb_rd) || wb_data != $past(wb_data)))
    else
    begin
        errors = errors + 1;
        $display("** Error at %0t: same writeback repeated on two cycles", $time);
    end

    initial
    begin
        int               e;
        int               kind;
        bit               last_first;
        logic [WIDTH-1:0] sq_vals[7];
        logic [WIDTH-1:0] dv_a[6];
        logic [WIDTH-1:0] dv_b[6];
        sq_vals = '{0, 1, 32'hFFFFFFFF, 4, 144, 32'h40000000, 152399025};
        dv_a    = '{1, 10, 12345, 32'hFFFFFFFF, 32'hFFFFFFFF, 7};
        dv_b    = '{1, 3, 0, 1, 32'hFFFFFFFF, 2}; // a zero divisor and a truncated quotient.
        void'($urandom(SEED));
        reset  = 1'b1;
        issue  = 1'b0;
        opcode = '0;
        funct7 = '0;
        rd     = '0;
        rs1    = '0;
        rs2    = '0;
        repeat (2) @(posedge CLK);
        #1;
        reset = 1'b0;
        expect_true(!sqrt_busy && !div_busy && !wb_valid, "outputs not idle after reset");

        foreach (sq_vals[i])
        begin
            send_at(edges + 1, OPCODE_FP, FUNCT7_FSQRT, sq_vals[i], rand_operand(), 1'b1);
            drain_results();
        end
        repeat (6)
        begin
            send_at(edges + 1, OPCODE_FP, FUNCT7_FSQRT, $urandom, '0, 1'b1);
            drain_results();
        end
        foreach (dv_a[i])
        begin
            send_at(edges + 1, OPCODE_FP, FUNCT7_FDIV, dv_a[i], dv_b[i], 1'b1);
            drain_results();
        end
        repeat (6)
        begin
            send_at(edges + 1, OPCODE_FP, FUNCT7_FDIV, rand_operand(), rand_operand(), 1'b1);
            drain_results();
        end

        // divide first so both units finish on the same edge.
        slack = 1;
        for (int round = 0; round < 4; round++)
        begin
            wb_order.delete();
            e = edges + 1;
            send_at(e, OPCODE_FP, FUNCT7_FDIV, rand_operand(), rand_operand(), 1'b1);
            send_at(e + DIV_ITER - SQRT_ITER, OPCODE_FP, FUNCT7_FSQRT, $urandom, '0, 1'b1);
            drain_results();
            expect_true(wb_order.size() == 2, "contended results did not both arrive");
            if (round > 0)
                expect_true(wb_order[0] != last_first, "tie winner did not alternate");
            last_first = wb_order[0];
        end

        slack = 0;
        e = edges + 1;
        send_at(e, OPCODE_FP, FUNCT7_FSQRT, 32'd1000000, '0, 1'b1);
        send_at(e + 3, OPCODE_FP, FUNCT7_FSQRT, 32'd9, '0, 1'b0);
        send_at(e + 5, OPCODE_FP, FUNCT7_FDIV, 32'd100, 32'd7, 1'b1);
        send_at(e + 6, OPCODE_FP, FUNCT7_FDIV, 32'd5, 32'd5, 1'b0);
        drain_results();

        send_at(edges + 1, 7'b0110011, FUNCT7_FSQRT, 32'd16, '0, 1'b0);
        send_at(edges + 1, OPCODE_FP, 7'b0000000, 32'd16, 32'd2, 1'b0);
        send_at(edges + 1, 7'b1010111, FUNCT7_FDIV, 32'd16, 32'd2, 1'b0);
        repeat (DIV_ITER + 4) @(posedge CLK); // any writeback here is flagged by the monitor.
        #1;

        slack = 1;
        repeat (24)
        begin
            kind = $urandom_range(0, 4);
            if (kind == 4)
                send_at(edges + 1, OPCODE_FP, 7'b0000100, rand_operand(), rand_operand(), 1'b0);
            else
            begin
                await_idle(kind[0]);
                send_at(edges + 1 + $urandom_range(0, 2), OPCODE_FP,
                        kind[0] ? FUNCT7_FDIV : FUNCT7_FSQRT, rand_operand(), rand_operand(), 1'b1);
            end
        end
        drain_results();
        finish_run();
    end

endmodule

// ==== rtl/fxp_coproc.sv ====
`timescale 1ns/1ps

module fxp_coproc
    import fxp_pkg::*;
(
    input  logic                CLK,
    input  logic                reset,
    input  logic                issue,
    input  logic [6:0]          opcode,
    input  logic [6:0]          funct7,
    input  logic [REG_BITS-1:0] rd,
    input  logic [WIDTH-1:0]    rs1,
    input  logic [WIDTH-1:0]    rs2,
    output logic                sqrt_busy,
    output logic                div_busy,
    output logic                wb_valid,
    output logic [REG_BITS-1:0] wb_rd,
    output logic [WIDTH-1:0]    wb_data
);

    logic sqrt_start;
    logic div_start;

    result_if sq_res ();
    result_if dv_res ();

    fxp_decoder u_decoder
    (
        .issue      (issue),
        .opcode     (opcode),
        .funct7     (funct7),
        .sqrt_start (sqrt_start),
        .div_start  (div_start)
    );

    sqrt_unit u_sqrt
    (
        .CLK   (CLK),
        .reset (reset),
        .start (sqrt_start),
        .rs1   (rs1),
        .rd    (rd),
        .busy  (sqrt_busy),
        .res   (sq_res.unit)
    );

    div_unit u_div
    (
        .CLK   (CLK),
        .reset (reset),
        .start (div_start),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .busy  (div_busy),
        .res   (dv_res.unit)
    );

    writeback_arbiter u_arbiter
    (
        .CLK      (CLK),
        .reset    (reset),
        .sq       (sq_res.arbiter),
        .dv       (dv_res.arbiter),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

// ==== rtl/writeback_arbiter.sv ====
`timescale 1ns/1ps

module writeback_arbiter
    import fxp_pkg::*;
(
    input  logic                CLK,
    input  logic                reset,
    result_if.arbiter           sq,
    result_if.arbiter           dv,
    output logic                wb_valid,
    output logic [REG_BITS-1:0] wb_rd,
    output logic [WIDTH-1:0]    wb_data
);

    logic prio_dv; // divide wins the next tie.
    logic both;
    logic gnt_sq;
    logic gnt_dv;

    assign both   = sq.pending && dv.pending;
    assign gnt_dv = dv.pending && (!sq.pending || prio_dv);
    assign gnt_sq = sq.pending && !gnt_dv;

    assign sq.grant = gnt_sq;
    assign dv.grant = gnt_dv;

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            prio_dv  <= 1'b0;
            wb_valid <= 1'b0;
        end
        else
        begin
            wb_valid <= gnt_sq || gnt_dv;
            if (both)
                prio_dv <= !prio_dv; // loser of this tie goes first next time.
        end
    end

    always_ff @(posedge CLK)
    begin
        if (gnt_dv)
        begin
            wb_rd   <= dv.rd;
            wb_data <= dv.data;
        end
        else if (gnt_sq)
        begin
            wb_rd   <= sq.rd;
            wb_data <= sq.data;
        end
    end

endmodule

// ==== rtl/div_unit.sv ====
`timescale 1ns/1ps

module div_unit
    import fxp_pkg::*;
(
    input  logic                CLK,
    input  logic                reset,
    input  logic                start,
    input  logic [WIDTH-1:0]    rs1,
    input  logic [WIDTH-1:0]    rs2,
    input  logic [REG_BITS-1:0] rd,
    output logic                busy,
    result_if.unit              res
);

    unit_state_t state;

    logic [DIV_CNT_W-1:0] cnt;
    logic [REG_BITS-1:0]  rd_q;

    logic [WIDTH-1:0]      dvsr;
    logic [WIDTH-1:0]      rem, rem_next;
    logic [DIVIDEND_W-1:0] quo, quo_next; // dividend shifts out as quotient shifts in.
    logic [WIDTH:0]        shifted;
    logic [WIDTH+1:0]      diff;

    always_comb
    begin
        shifted = {rem, quo[DIVIDEND_W-1]};
        diff    = {1'b0, shifted} - {2'b00, dvsr};
        if (!diff[WIDTH+1])
        begin
            rem_next = diff[WIDTH-1:0];
            quo_next = {quo[DIVIDEND_W-2:0], 1'b1};
        end
        else
        begin
            rem_next = shifted[WIDTH-1:0]; // restore.
            quo_next = {quo[DIVIDEND_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        state <= ST_RUN;
                        cnt   <= '0;
                    end
                end
                ST_RUN:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DIV_CNT_W'(DIV_ITER - 1))
                        state <= ST_PENDING;
                end
                ST_PENDING:
                begin
                    if (res.grant)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // a zero divisor never fails the trial subtract, so the quotient fills with ones.
    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && start)
        begin
            quo  <= {rs1, {FBITS{1'b0}}};
            rem  <= '0;
            dvsr <= rs2;
            rd_q <= rd;
        end
        else if (state == ST_RUN)
        begin
            quo <= quo_next;
            rem <= rem_next;
        end
    end

    assign busy        = (state != ST_IDLE);
    assign res.pending = (state == ST_PENDING);
    assign res.rd      = rd_q;
    assign res.data    = quo[WIDTH-1:0]; // truncated to the register width.

endmodule

// ==== rtl/sqrt_unit.sv ====
`timescale 1ns/1ps

module sqrt_unit
    import fxp_pkg::*;
(
    input  logic                CLK,
    input  logic                reset,
    input  logic                start,
    input  logic [WIDTH-1:0]    rs1,
    input  logic [REG_BITS-1:0] rd,
    output logic                busy,
    result_if.unit              res
);

    unit_state_t state;

    logic [SQRT_CNT_W-1:0] cnt;
    logic [REG_BITS-1:0]   rd_q;

    logic [WIDTH-1:0] x, x_next;      // radicand bits still to be brought down.
    logic [WIDTH-1:0] q, q_next;      // partial root.
    logic [WIDTH+1:0] ac, ac_next;    // partial remainder.
    logic [WIDTH+1:0] trial;

    always_comb
    begin
        trial = ac - {q, 2'b01};
        if (!trial[WIDTH+1])
        begin
            {ac_next, x_next} = {trial[WIDTH-1:0], x, 2'b00};
            q_next = {q[WIDTH-2:0], 1'b1};
        end
        else
        begin
            {ac_next, x_next} = {ac[WIDTH-1:0], x, 2'b00};
            q_next = {q[WIDTH-2:0], 1'b0};
        end
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        state <= ST_RUN;
                        cnt   <= '0;
                    end
                end
                ST_RUN:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == SQRT_CNT_W'(SQRT_ITER - 1))
                        state <= ST_PENDING; // last digit lands this edge.
                end
                ST_PENDING:
                begin
                    if (res.grant)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && start)
        begin
            {ac, x} <= {{WIDTH{1'b0}}, rs1, 2'b00};
            q       <= '0;
            rd_q    <= rd;
        end
        else if (state == ST_RUN)
        begin
            ac <= ac_next;
            x  <= x_next;
            q  <= q_next;
        end
    end

    assign busy        = (state != ST_IDLE);
    assign res.pending = (state == ST_PENDING);
    assign res.rd      = rd_q;
    assign res.data    = q;

endmodule

// ==== rtl/fxp_decoder.sv ====
`timescale 1ns/1ps

module fxp_decoder
    import fxp_pkg::*;
(
    input  logic       issue,
    input  logic [6:0] opcode,
    input  logic [6:0] funct7,
    output logic       sqrt_start,
    output logic       div_start
);

    fxp_op_t op;

    always_comb
    begin
        op = OP_NONE;
        if (opcode == OPCODE_FP)
        begin
            case (funct7)
                FUNCT7_FSQRT: op = OP_SQRT;
                FUNCT7_FDIV:  op = OP_DIV;
                default:      op = OP_NONE; // other fp ops are not ours.
            endcase
        end
    end

    // strobes last only for the issue cycle.
    assign sqrt_start = issue && (op == OP_SQRT);
    assign div_start  = issue && (op == OP_DIV);

endmodule

// ==== rtl/result_if.sv ====
`timescale 1ns/1ps

interface result_if
    import fxp_pkg::*;
();

    logic                pending; // held until granted.
    logic [REG_BITS-1:0] rd;
    logic [WIDTH-1:0]    data;
    logic                grant;   // single cycle.

    modport unit
    (
        output pending, rd, data,
        input  grant
    );

    modport arbiter
    (
        input  pending, rd, data,
        output grant
    );

endinterface

// ==== rtl/fxp_pkg.sv ====
package fxp_pkg;

    localparam int WIDTH    = 32;
    localparam int FBITS    = 10;
    localparam int REG_BITS = 5;

    // the radicand is scaled by 2^FBITS, so each iteration consumes two of those bits.
    localparam int SQRT_ITER  = (WIDTH + FBITS) / 2;
    localparam int DIV_ITER   = WIDTH + FBITS;
    localparam int DIVIDEND_W = WIDTH + FBITS;

    localparam int SQRT_CNT_W = $clog2(SQRT_ITER);
    localparam int DIV_CNT_W  = $clog2(DIV_ITER);

    localparam logic [6:0] OPCODE_FP    = 7'b1010011;
    localparam logic [6:0] FUNCT7_FSQRT = 7'b0101100;
    localparam logic [6:0] FUNCT7_FDIV  = 7'b0001100;

    typedef enum logic [1:0]
    {
        OP_NONE,
        OP_SQRT,
        OP_DIV
    } fxp_op_t;

    // shared by both iterative units.
    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_RUN,
        ST_PENDING
    } unit_state_t;

endpackage
